/* design/axi_bus_pkg.sv */
`default_nettype none

package axi_bus_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_LEN_W  = 8;
    localparam int AXI_STRB_W = 4;

    typedef enum logic [1:0] {
        FIXED = 2'd0,  // same address on every beat
        INCR  = 2'd1   // address steps by one per beat
    } axi_burst_e;     // codes 2 and 3 are reserved

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axi_resp_e;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        axi_burst_e            burst;
    } axi_aw_t;  // no len, write bursts end on w.last

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_LEN_W-1:0]  len;    // beats minus one
        axi_burst_e            burst;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        axi_resp_e             resp;
        logic                  last;
    } axi_r_t;

    function automatic logic burst_legal(axi_burst_e burst);
        return (burst == FIXED) || (burst == INCR);
    endfunction

endpackage

`default_nettype wire

/* design/axi_rd_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_rd_channel (
    input  logic                                 clk,
    input  logic                                 jtag_rstn_sync,
    input  axi_bus_pkg::axi_ar_t                 ar,
    input  logic                                 ar_valid,
    output logic                                 ar_ready,
    output axi_bus_pkg::axi_r_t                  r,
    output logic                                 r_valid,
    input  logic                                 r_ready,
    output logic [axi_bus_pkg::AXI_ADDR_W-1:0]   rd_addr,
    input  logic [axi_bus_pkg::AXI_DATA_W-1:0]   rd_data
);

    import axi_bus_pkg::*;
    import jtag_regs_pkg::*;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    rd_state_e             state_q;
    rd_state_e             state_d;
    logic [AXI_ID_W-1:0]   id_q;
    logic [AXI_LEN_W-1:0]  len_q;
    logic [AXI_ADDR_W-1:0] addr_q;
    axi_burst_e            burst_q;
    logic [AXI_LEN_W-1:0]  beat_q;  // beats already handed over
    logic                  err_q;   // set after the first bad beat
    logic                  ar_fire;
    logic                  r_fire;
    logic                  beat_ok;
    logic                  bad;

    assign ar_ready = (state_q == RD_IDLE);
    assign r_valid  = (state_q == RD_DATA);

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign beat_ok = burst_legal(burst_q) && addr_is_reg(addr_q);
    assign bad     = !beat_ok || err_q;

    assign rd_addr = addr_q;  // bank answers in the same cycle

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (ar_fire) state_d = RD_DATA;
            RD_DATA: if (r_fire && r.last) state_d = RD_IDLE;
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state_q <= RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q    <= ar.id;
            len_q   <= ar.len;
            addr_q  <= ar.addr;
            burst_q <= ar.burst;
        end else if (r_fire && (burst_q == INCR)) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (ar_fire) begin
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            err_q  <= bad;  // sticks to the end of the burst
        end
    end

    always_comb begin
        r.id   = id_q;
        r.data = bad ? RD_ERR_DATA : rd_data;
        r.resp = bad ? SLVERR : OKAY;
        r.last = (state_q == RD_DATA) && (beat_q == len_q);  // len+1 beats
    end

endmodule

`default_nettype wire

/* design/axi_wr_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_channel (
    input  logic                   clk,
    input  logic                   jtag_rstn_sync,
    input  axi_bus_pkg::axi_aw_t   aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_bus_pkg::axi_w_t    w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi_bus_pkg::axi_b_t    b,
    output logic                   b_valid,
    input  logic                   b_ready,
    output jtag_regs_pkg::reg_wr_t reg_wr
);

    import axi_bus_pkg::*;
    import jtag_regs_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e             state_q;
    wr_state_e             state_d;
    logic [AXI_ID_W-1:0]   id_q;
    logic [AXI_ADDR_W-1:0] addr_q;  // address of the current beat
    axi_burst_e            burst_q;
    logic                  err_q;   // sticky over the burst
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;
    logic                  beat_ok;

    assign aw_ready = (state_q == WR_IDLE);
    assign w_ready  = (state_q == WR_DATA);  // registers never stall
    assign b_valid  = (state_q == WR_RESP);

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;
    assign beat_ok = burst_legal(burst_q) && addr_is_reg(addr_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (aw_fire) state_d = WR_DATA;
            WR_DATA: if (w_fire && w.last) state_d = WR_RESP;
            WR_RESP: if (b_fire) state_d = WR_IDLE;  // hold under back-pressure
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state_q <= WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q    <= aw.id;
            addr_q  <= aw.addr;
            burst_q <= aw.burst;
        end else if (w_fire && (burst_q == INCR)) begin
            addr_q <= addr_q + 1'b1;  // may run past 7 into error space
        end
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            err_q <= 1'b0;
        end else if (aw_fire) begin
            err_q <= 1'b0;  // new burst
        end else if (w_fire && !beat_ok) begin
            err_q <= 1'b1;
        end
    end

    always_comb begin
        b.id   = id_q;
        b.resp = err_q ? SLVERR : OKAY;
    end

    // bad beats are accepted and dropped
    always_comb begin
        reg_wr.en   = w_fire && beat_ok;
        reg_wr.addr = reg_addr_e'(addr_q);
        reg_wr.data = w.data;
        reg_wr.strb = w.strb;
    end

endmodule

`default_nettype wire

/* design/jtag_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_axi_slave (
    input  logic                                clk,
    input  logic                                jtag_rstn_sync,
    input  axi_bus_pkg::axi_aw_t                aw,
    input  logic                                aw_valid,
    output logic                                aw_ready,
    input  axi_bus_pkg::axi_w_t                 w,
    input  logic                                w_valid,
    output logic                                w_ready,
    output axi_bus_pkg::axi_b_t                 b,
    output logic                                b_valid,
    input  logic                                b_ready,
    input  axi_bus_pkg::axi_ar_t                ar,
    input  logic                                ar_valid,
    output logic                                ar_ready,
    output axi_bus_pkg::axi_r_t                 r,
    output logic                                r_valid,
    input  logic                                r_ready,
    output logic                                tck,
    output logic                                key_ctrl_enable,
    output logic [axi_bus_pkg::AXI_DATA_W-1:0]  key_pattern,
    output logic                                lab_fpga_power_on
);

    import axi_bus_pkg::*;
    import jtag_regs_pkg::*;

    reg_wr_t               reg_wr;    // write strobe into the bank
    logic [AXI_ADDR_W-1:0] rd_addr;
    logic [AXI_DATA_W-1:0] rd_data;
    logic [TCK_CNT_W-1:0]  tck_high;
    logic [TCK_CNT_W-1:0]  tck_low;

    axi_wr_channel i_axi_wr_channel (
        .clk            (clk),
        .jtag_rstn_sync (jtag_rstn_sync),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .reg_wr         (reg_wr)
    );

    axi_rd_channel i_axi_rd_channel (
        .clk            (clk),
        .jtag_rstn_sync (jtag_rstn_sync),
        .ar             (ar),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r              (r),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data)
    );

    jtag_reg_bank i_jtag_reg_bank (
        .clk               (clk),
        .jtag_rstn_sync    (jtag_rstn_sync),
        .reg_wr            (reg_wr),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .tck_high          (tck_high),
        .tck_low           (tck_low),
        .key_ctrl_enable   (key_ctrl_enable),
        .key_pattern       (key_pattern),
        .lab_fpga_power_on (lab_fpga_power_on)
    );

    tck_gen i_tck_gen (
        .clk            (clk),
        .jtag_rstn_sync (jtag_rstn_sync),
        .tck_high       (tck_high),
        .tck_low        (tck_low),
        .tck            (tck)
    );

endmodule

`default_nettype wire

/* design/jtag_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_reg_bank (
    input  logic                                 clk,
    input  logic                                 jtag_rstn_sync,
    input  jtag_regs_pkg::reg_wr_t               reg_wr,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]   rd_addr,
    output logic [axi_bus_pkg::AXI_DATA_W-1:0]   rd_data,
    output logic [jtag_regs_pkg::TCK_CNT_W-1:0]  tck_high,
    output logic [jtag_regs_pkg::TCK_CNT_W-1:0]  tck_low,
    output logic                                 key_ctrl_enable,
    output logic [axi_bus_pkg::AXI_DATA_W-1:0]   key_pattern,
    output logic                                 lab_fpga_power_on
);

    import axi_bus_pkg::*;
    import jtag_regs_pkg::*;

    tck_speed_t            speed_q;
    logic                  key_en_q;
    logic [AXI_DATA_W-1:0] key_pat_q;
    logic                  power_q;

    // replaces only the bytes whose strobe is set
    function automatic logic [AXI_DATA_W-1:0] merge_bytes(
        input logic [AXI_DATA_W-1:0] old_val,
        input logic [AXI_DATA_W-1:0] new_val,
        input logic [AXI_STRB_W-1:0] strb
    );
        logic [AXI_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            speed_q.high <= TCK_PERIOD_RST;
            speed_q.low  <= TCK_PERIOD_RST;
            key_en_q     <= 1'b0;
            key_pat_q    <= '0;
            power_q      <= 1'b0;  // target stays unpowered
        end else if (reg_wr.en) begin
            case (reg_wr.addr)
                TCK_SPEED: speed_q <= merge_bytes(speed_q, reg_wr.data, reg_wr.strb);
                KEY_EN: begin
                    if (reg_wr.strb[0]) key_en_q <= reg_wr.data[0];  // bit 0 only
                end
                KEY_DATA: key_pat_q <= merge_bytes(key_pat_q, reg_wr.data, reg_wr.strb);
                POWER: begin
                    if (reg_wr.strb[0]) power_q <= reg_wr.data[0];
                end
                default: ;  // channel filters undefined addresses
            endcase
        end
    end

    always_comb begin
        case (rd_addr)
            TCK_SPEED: rd_data = speed_q;
            KEY_EN:    rd_data = {{(AXI_DATA_W-1){1'b0}}, key_en_q};
            KEY_DATA:  rd_data = key_pat_q;
            POWER:     rd_data = {{(AXI_DATA_W-1){1'b0}}, power_q};
            default:   rd_data = RD_ERR_DATA;
        endcase
    end

    assign tck_high          = speed_q.high;
    assign tck_low           = speed_q.low;
    assign key_ctrl_enable   = key_en_q;
    assign key_pattern       = key_pat_q;
    assign lab_fpga_power_on = power_q;

endmodule

`default_nettype wire

/* design/jtag_regs_pkg.sv */
`default_nettype none

package jtag_regs_pkg;

    typedef enum logic [31:0] {
        TCK_SPEED = 32'd4,  // {high, low} tck periods
        KEY_EN    = 32'd5,
        KEY_DATA  = 32'd6,
        POWER     = 32'd7
    } reg_addr_e;

    localparam int TCK_CNT_W = 16;

    localparam logic [TCK_CNT_W-1:0] TCK_PERIOD_RST = 16'd1;

    // returned for undefined addresses and bad read beats
    localparam logic [axi_bus_pkg::AXI_DATA_W-1:0] RD_ERR_DATA = 32'hFFFF_FFFF;

    typedef struct packed {
        logic [TCK_CNT_W-1:0] high;  // upper half
        logic [TCK_CNT_W-1:0] low;   // lower half
    } tck_speed_t;

    typedef struct packed {
        logic                               en;    // one cycle per legal beat
        reg_addr_e                          addr;
        logic [axi_bus_pkg::AXI_DATA_W-1:0] data;
        logic [axi_bus_pkg::AXI_STRB_W-1:0] strb;
    } reg_wr_t;

    function automatic logic addr_is_reg(logic [axi_bus_pkg::AXI_ADDR_W-1:0] addr);
        return (addr >= TCK_SPEED) && (addr <= POWER);
    endfunction

endpackage

`default_nettype wire

/* design/tck_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tck_gen (
    input  logic                                clk,
    input  logic                                jtag_rstn_sync,
    input  logic [jtag_regs_pkg::TCK_CNT_W-1:0] tck_high,
    input  logic [jtag_regs_pkg::TCK_CNT_W-1:0] tck_low,
    output logic                                tck
);

    import jtag_regs_pkg::*;

    logic [TCK_CNT_W-1:0] cnt_q;     // clk cycles left in this phase
    logic [TCK_CNT_W-1:0] next_len;  // length of the coming phase
    logic                 tck_q;
    logic                 phase_end;

    assign phase_end = (cnt_q <= 1);

    // sampled only at the phase change
    always_comb begin
        next_len = tck_q ? tck_low : tck_high;
        if (next_len == '0) next_len = 1;  // zero acts as one
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            tck_q <= 1'b0;
            cnt_q <= TCK_PERIOD_RST;  // first low phase at reset length
        end else if (phase_end) begin
            tck_q <= !tck_q;
            cnt_q <= next_len;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign tck = tck_q;

endmodule

`default_nettype wire

/* flist.f */
design/axi_bus_pkg.sv
design/jtag_regs_pkg.sv
design/axi_wr_channel.sv
design/axi_rd_channel.sv
design/jtag_reg_bank.sv
design/tck_gen.sv
design/jtag_axi_slave.sv
verification/jtag_axi_checker.sv
verification/tb_jtag_axi_slave.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_jtag_axi_slave -f flist.f

sim_out=$(./obj_dir/Vtb_jtag_axi_slave)
echo "$sim_out"

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* verification/jtag_axi_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_axi_checker (
    input  logic                               clk,
    input  logic                               jtag_rstn_sync,
    input  axi_bus_pkg::axi_aw_t               aw,
    input  logic                               aw_valid,
    input  logic                               aw_ready,
    input  axi_bus_pkg::axi_w_t                w,
    input  logic                               w_valid,
    input  logic                               w_ready,
    input  axi_bus_pkg::axi_b_t                b,
    input  logic                               b_valid,
    input  logic                               b_ready,
    input  axi_bus_pkg::axi_ar_t               ar,
    input  logic                               ar_valid,
    input  logic                               ar_ready,
    input  axi_bus_pkg::axi_r_t                r,
    input  logic                               r_valid,
    input  logic                               r_ready,
    input  logic                               tck,
    input  logic                               key_ctrl_enable,
    input  logic [axi_bus_pkg::AXI_DATA_W-1:0] key_pattern,
    input  logic                               lab_fpga_power_on,
    output logic [31:0]                        error_count,
    output logic [31:0]                        wr_count,
    output logic [31:0]                        rd_count
);

    import axi_bus_pkg::*;
    import jtag_regs_pkg::*;

    logic [31:0] m_speed;      // register model
    logic [31:0] m_key_pat;
    logic        m_key_en;
    logic        m_power;
    int          wr_st;        // 0 idle, 1 data, 2 response
    logic [3:0]  wr_id;
    logic [31:0] wr_addr;
    logic [1:0]  wr_burst;
    logic        wr_err;
    int          rd_st;        // 0 idle, 1 data
    logic [3:0]  rd_id;
    logic [31:0] rd_addr;
    logic [7:0]  rd_len;
    logic [7:0]  rd_beat;
    logic [1:0]  rd_burst;
    logic        rd_err;
    logic        tck_prev;
    logic        phase_known;  // first phase after reset is not measured
    logic        rst_seen = 1'b0;  // reset has reached the DUT registers
    int          run_cnt;
    int          phase_exp;
    int          pend_len;
    int          errs = 0;
    int          wr_done = 0;
    int          rd_done = 0;

    assign error_count = errs;
    assign wr_count    = wr_done;
    assign rd_count    = rd_done;

    function automatic logic beat_legal(input logic [1:0] burst, input logic [31:0] addr);
        return (burst <= 2'd1) && (addr >= TCK_SPEED) && (addr <= POWER);
    endfunction

    function automatic logic [31:0] merge_strobes(input logic [31:0] old_val,
                                                  input logic [31:0] new_val,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // reference for what a legal read beat returns
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        case (addr)
            TCK_SPEED: return m_speed;
            KEY_EN:    return {31'd0, m_key_en};
            KEY_DATA:  return m_key_pat;
            POWER:     return {31'd0, m_power};
            default:   return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            errs++;
            $display("CHECK FAILED %s at %0t: got %h expected %h", name, $time, got, want);
        end
    endtask

    always @(posedge clk) begin : compare
        axi_r_t      exp_r;
        axi_b_t      exp_b;
        logic        bad;
        logic [15:0] nxt;
        // register outputs still hold the state from before this edge
        if (rst_seen) begin
            check_value("key_ctrl_enable", 64'(key_ctrl_enable), 64'(m_key_en));
            check_value("key_pattern", 64'(key_pattern), 64'(m_key_pat));
            check_value("lab_fpga_power_on", 64'(lab_fpga_power_on), 64'(m_power));
        end
        if (!jtag_rstn_sync) begin
            m_speed     = 32'h0001_0001;
            m_key_pat   = 32'd0;
            m_key_en    = 1'b0;
            m_power     = 1'b0;
            wr_st       = 0;
            rd_st       = 0;
            tck_prev    = 1'b0;
            phase_known = 1'b0;
            run_cnt     = 0;
            if (rst_seen) begin
                check_value("aw_ready", 64'(aw_ready), 64'd1);
                check_value("ar_ready", 64'(ar_ready), 64'd1);
                check_value("w_ready", 64'(w_ready), 64'd0);
                check_value("b_valid", 64'(b_valid), 64'd0);
                check_value("r_valid", 64'(r_valid), 64'd0);
                check_value("r_last", 64'(r.last), 64'd0);
                check_value("tck", 64'(tck), 64'd0);
            end
            rst_seen = 1'b1;
        end else begin
            check_value("aw_ready", 64'(aw_ready), 64'(wr_st == 0));
            check_value("w_ready", 64'(w_ready), 64'(wr_st == 1));
            check_value("b_valid", 64'(b_valid), 64'(wr_st == 2));
            check_value("ar_ready", 64'(ar_ready), 64'(rd_st == 0));
            check_value("r_valid", 64'(r_valid), 64'(rd_st == 1));

            // tck phase length set by the speed value at the toggle
            if (tck != tck_prev) begin
                if (phase_known) check_value("tck phase", 64'(run_cnt), 64'(phase_exp));
                phase_exp   = pend_len;
                phase_known = 1'b1;
                run_cnt     = 1;
            end else begin
                run_cnt++;
            end
            nxt      = tck ? m_speed[15:0] : m_speed[31:16];
            pend_len = (nxt == 16'd0) ? 1 : int'(nxt);
            tck_prev = tck;

            // reads see the registers before this edge's write
            if (rd_st == 1) begin
                bad        = !beat_legal(rd_burst, rd_addr) || rd_err;
                exp_r.id   = rd_id;
                exp_r.data = bad ? 32'hFFFF_FFFF : expected_read(rd_addr);
                exp_r.resp = bad ? SLVERR : OKAY;
                exp_r.last = (rd_beat == rd_len);
                check_value("r", 64'(r), 64'(exp_r));
                if (r_ready) begin
                    rd_err  = bad;
                    rd_beat = rd_beat + 8'd1;
                    if (rd_burst == INCR) rd_addr = rd_addr + 32'd1;
                    if (exp_r.last) begin
                        rd_st = 0;
                        rd_done++;
                    end
                end
            end else if (ar_valid) begin
                rd_id    = ar.id;
                rd_addr  = ar.addr;
                rd_len   = ar.len;
                rd_burst = ar.burst;
                rd_beat  = 8'd0;
                rd_err   = 1'b0;
                rd_st    = 1;
            end

            case (wr_st)
                0: if (aw_valid) begin
                    wr_id    = aw.id;
                    wr_addr  = aw.addr;
                    wr_burst = aw.burst;
                    wr_err   = 1'b0;
                    wr_st    = 1;
                end
                1: if (w_valid) begin
                    if (beat_legal(wr_burst, wr_addr)) begin
                        case (wr_addr)
                            TCK_SPEED: m_speed = merge_strobes(m_speed, w.data, w.strb);
                            KEY_EN:    if (w.strb[0]) m_key_en = w.data[0];
                            KEY_DATA:  m_key_pat = merge_strobes(m_key_pat, w.data, w.strb);
                            default:   if (w.strb[0]) m_power = w.data[0];
                        endcase
                    end else begin
                        wr_err = 1'b1;  // dropped beat
                    end
                    if (wr_burst == INCR) wr_addr = wr_addr + 32'd1;
                    if (w.last) wr_st = 2;
                end
                default: begin
                    exp_b.id   = wr_id;
                    exp_b.resp = wr_err ? SLVERR : OKAY;
                    check_value("b", 64'(b), 64'(exp_b));
                    if (b_ready) begin
                        wr_st = 0;
                        wr_done++;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verification/tb_jtag_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_axi_slave;

    import axi_bus_pkg::*;

    localparam int          CLK_PERIOD      = 100;
    localparam int          NUM_BURSTS      = 64;
    localparam int          WATCHDOG_CYCLES = NUM_BURSTS * 40 + 2000;
    localparam logic [15:0] LFSR_SEED       = 16'd27271;

    logic        clk;
    logic        jtag_rstn_sync;
    axi_aw_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    axi_b_t      b;
    logic        b_valid;
    logic        b_ready;
    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;
    logic        tck;
    logic        key_ctrl_enable;
    logic [31:0] key_pattern;
    logic        lab_fpga_power_on;
    logic [31:0] chk_errors;
    logic [31:0] chk_writes;
    logic [31:0] chk_reads;
    logic [15:0] lfsr;
    int          wr_sent;
    int          rd_sent;

    jtag_axi_slave i_jtag_axi_slave (.*);

    jtag_axi_checker i_jtag_axi_checker (
        .*,
        .error_count (chk_errors),
        .wr_count    (chk_writes),
        .rd_count    (chk_reads)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [1:0] burst, input int beats);
        logic [31:0] rnd;
        logic [31:0] beat_addr;
        logic        done;
        draw(4, rnd);
        aw.id    = rnd[3:0];
        aw.addr  = addr;
        aw.burst = axi_burst_e'(burst);
        aw_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = aw_ready;
        end
        @(negedge clk);
        aw_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            beat_addr = (burst == 2'd1) ? addr + 32'(i) : addr;
            draw(32, rnd);
            w.data = (beat_addr == 32'd4) ? (rnd & 32'h000F_000F) : rnd;  // short tck phases
            draw(4, rnd);
            w.strb  = rnd[3:0];
            w.last  = (i == beats - 1);
            w_valid = 1'b1;
            done    = 1'b0;
            while (!done) begin
                @(posedge clk);
                done = w_ready;
            end
            @(negedge clk);
        end
        w_valid = 1'b0;
        w.last  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            draw(1, rnd);
            b_ready = rnd[0];  // random back-pressure
            @(posedge clk);
            done = b_valid && b_ready;
            @(negedge clk);
        end
        b_ready = 1'b0;
        wr_sent++;
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [1:0] burst,
                              input logic [7:0] len);
        logic [31:0] rnd;
        logic        done;
        draw(4, rnd);
        ar.id    = rnd[3:0];
        ar.addr  = addr;
        ar.len   = len;
        ar.burst = axi_burst_e'(burst);
        ar_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = ar_ready;
        end
        @(negedge clk);
        ar_valid = 1'b0;
        done     = 1'b0;
        while (!done) begin
            draw(1, rnd);
            r_ready = rnd[0];
            @(posedge clk);
            done = r_valid && r_ready && r.last;
            @(negedge clk);
        end
        r_ready = 1'b0;
        rd_sent++;
    endtask

    initial begin : main
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [1:0]  burst;
        int          beats;
        int          count_errs;
        jtag_rstn_sync = 1'b0;
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        b_ready    = 1'b0;
        ar         = '0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        lfsr       = LFSR_SEED;
        wr_sent    = 0;
        rd_sent    = 0;
        count_errs = 0;
        repeat (2) @(negedge clk);
        jtag_rstn_sync = 1'b1;

        for (int i = 0; i < NUM_BURSTS; i++) begin
            draw(8, rnd);
            addr  = 32'd4 + 32'(rnd[1:0]);
            burst = 2'd1;
            beats = 1;
            case (i % 4)
                1: begin
                    burst = {1'b0, rnd[2]};
                    if (burst == 2'd1) beats = int'(rnd[4:3]) % (4 - int'(rnd[1:0])) + 1;
                    else beats = int'(rnd[4:3]) + 1;
                end
                2: begin
                    case (rnd[3:2])
                        2'd0: addr = 32'(rnd[1:0]);
                        2'd1: addr = 32'd8 + 32'(rnd[7:4]);
                        2'd2: begin
                            burst = {1'b1, rnd[4]};  // reserved code
                            beats = 2;
                        end
                        default: begin
                            addr  = 32'd6;  // runs past 7
                            beats = 4;
                        end
                    endcase
                end
                3: addr = 32'd4;
                default: ;
            endcase
            write_burst(addr, burst, beats);
            read_burst(addr, burst, 8'(beats - 1));
            if (i % 4 == 3) repeat (40) @(negedge clk);  // let tck run at the new speed
        end

        repeat (4) @(negedge clk);
        if (chk_writes != 32'(wr_sent)) begin
            count_errs++;
            $display("CHECK FAILED write bursts: got %h expected %h", chk_writes, wr_sent);
        end
        if (chk_reads != 32'(rd_sent)) begin
            count_errs++;
            $display("CHECK FAILED read bursts: got %h expected %h", chk_reads, rd_sent);
        end
        $display("summary: %0d check errors, %0d count errors, %0d writes, %0d reads",
                 chk_errors, count_errs, wr_sent, rd_sent);
        if (chk_errors == 32'd0 && count_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
